//--- Makefile
# Verilator flow for the vector modular exponentiation unit

TB_TOP = ntm_vector_exponentiator_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f ntm_vector_exponentiator.f --top-module ntm_vector_exponentiator
	verilator --lint-only --timing -f ntm_vector_exponentiator.f --top-module $(TB_TOP)

sim:
	verilator --binary --timing --assert -f ntm_vector_exponentiator.f \
		--top-module $(TB_TOP) -Mdir obj_dir
	./obj_dir/V$(TB_TOP) | tee sim.log
	@if grep -q "Done: errors found" sim.log || ! grep -q "Done: no errors" sim.log; then \
		echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log

//--- ntm_vector_exponentiator.f
+incdir+verilog
verilog/ntm_exp_pkg.sv
verilog/ntm_modular_multiplier.sv
verilog/ntm_scalar_exponentiator.sv
verilog/ntm_vector_input.sv
verilog/ntm_vector_output.sv
verilog/ntm_vector_exponentiator.sv
tests/ntm_vector_exponentiator_tb.sv

//--- tests/ntm_vector_exponentiator_tb.sv
//////////////////////////////////////////////////
// Testbench for the vector modular exponentiation
// unit. Random and directed vectors are checked
// against a repeated-multiplication model
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "ntm_exp_defs.svh"

module ntm_vector_exponentiator_tb;

  localparam int WAIT_LIMIT  = 2000;
  localparam int RAND_VECTORS = 12;

  //////////////////////////////////////////////////
  // DUT signals
  //////////////////////////////////////////////////

  logic                         CLK;
  logic                         RST;
  logic                         start;
  logic [`NTM_INDEX_WIDTH-1:0]  size_in;
  logic                         data_a_in_enable;
  logic                         data_b_in_enable;
  logic [`NTM_DATA_WIDTH-1:0]   modulo_in;
  logic [`NTM_DATA_WIDTH-1:0]   data_a_in;
  logic [`NTM_DATA_WIDTH-1:0]   data_b_in;
  logic                         ready;
  logic                         data_out_enable;
  logic [`NTM_DATA_WIDTH-1:0]   data_out;

  // Bookkeeping
  logic [31:0]                  lfsr;
  int                           errors;
  int                           checks;
  bit                           aborted;
  int                           enable_count;
  int                           ready_count;
  int                           total_elements;
  int                           total_vectors;

  // Current vector, one entry per element
  logic [`NTM_DATA_WIDTH-1:0]   vec_base[$];
  logic [`NTM_DATA_WIDTH-1:0]   vec_exp[$];
  int                           vec_order[$];

  ntm_vector_exponentiator i_dut (
    .CLK              (CLK),
    .RST              (RST),
    .START            (start),
    .SIZE_IN          (size_in),
    .DATA_A_IN_ENABLE (data_a_in_enable),
    .DATA_B_IN_ENABLE (data_b_in_enable),
    .MODULO_IN        (modulo_in),
    .DATA_A_IN        (data_a_in),
    .DATA_B_IN        (data_b_in),
    .READY            (ready),
    .DATA_OUT_ENABLE  (data_out_enable),
    .DATA_OUT         (data_out)
  );

  // 100 ns period
  always #50 CLK = ~CLK;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] value);
    int k;
    value = '0;
    for (k = 0; k < n; k++) begin
      lfsr  = lfsr_next(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  // base ^ expo mod m by repeated multiplication
  task automatic model_modexp(input logic [15:0] base, input logic [15:0] expo,
                              input logic [15:0] m, output logic [15:0] result);
    logic [31:0] r;
    int          i;
    r = 32'd1 % {16'd0, m};
    for (i = 0; i < int'(expo); i++) begin
      r = (r * {16'd0, base}) % {16'd0, m};
    end
    result = r[15:0];
  endtask

  task automatic compare(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
      errors++;
    end
  endtask

  // Inputs change 5 ns after the rising edge
  task automatic next_cycle;
    @(posedge CLK);
    #5;
  endtask

  // No READY or DATA_OUT_ENABLE while idle
  // DATA_OUT is zero only before the first result
  task automatic check_idle_outputs(input int cycles, input bit check_data);
    int c;
    for (c = 0; c < cycles; c++) begin
      @(negedge CLK);
      compare("READY", 32'(ready), 32'd0);
      compare("DATA_OUT_ENABLE", 32'(data_out_enable), 32'd0);
      if (check_data) begin
        compare("DATA_OUT", 32'(data_out), 32'd0);
      end
    end
    next_cycle;
  endtask

  // Order 0 is A first, 1 is B first, 2 is same cycle
  task automatic send_pair(input logic [15:0] base, input logic [15:0] expo,
                           input int order);
    case (order)
      0: begin
        data_a_in        = base;
        data_a_in_enable = 1'b1;
        next_cycle;
        data_a_in_enable = 1'b0;
        data_a_in        = ~base;
        data_b_in        = expo;
        data_b_in_enable = 1'b1;
        next_cycle;
        data_b_in_enable = 1'b0;
        data_b_in        = ~expo;
      end
      1: begin
        data_b_in        = expo;
        data_b_in_enable = 1'b1;
        next_cycle;
        data_b_in_enable = 1'b0;
        data_b_in        = ~expo;
        data_a_in        = base;
        data_a_in_enable = 1'b1;
        next_cycle;
        data_a_in_enable = 1'b0;
        data_a_in        = ~base;
      end
      default: begin
        data_a_in        = base;
        data_b_in        = expo;
        data_a_in_enable = 1'b1;
        data_b_in_enable = 1'b1;
        next_cycle;
        data_a_in_enable = 1'b0;
        data_b_in_enable = 1'b0;
      end
    endcase
  endtask

  // Sample at the falling edge until the enable shows up
  task automatic wait_for_result(input logic [15:0] expected, input bit last);
    int cycles;
    bit found;
    cycles = 0;
    found  = 1'b0;
    while (!found && cycles < WAIT_LIMIT) begin
      @(negedge CLK);
      cycles++;
      found = data_out_enable;
    end
    if (!found) begin
      $display("Timeout at %0t: no DATA_OUT_ENABLE within %0d cycles", $time, WAIT_LIMIT);
      errors++;
      aborted = 1'b1;
    end else begin
      compare("DATA_OUT", 32'(data_out), 32'(expected));
      compare("READY", 32'(ready), 32'(last));
      next_cycle;
    end
  endtask

  // Whole vector from START to READY
  task automatic run_vector(input int n, input logic [15:0] m);
    int          i;
    int          enables_before;
    int          readies_before;
    logic [15:0] expected;
    enables_before = enable_count;
    readies_before = ready_count;
    start     = 1'b1;
    size_in   = `NTM_INDEX_WIDTH'(n);
    modulo_in = m;
    next_cycle;
    start     = 1'b0;
    for (i = 0; i < n && !aborted; i++) begin
      model_modexp(vec_base[i], vec_exp[i], m, expected);
      send_pair(vec_base[i], vec_exp[i], vec_order[i]);
      wait_for_result(expected, i == n - 1);
    end
    if (!aborted) begin
      compare("DATA_OUT_ENABLE count", 32'(enable_count - enables_before), 32'(n));
      compare("READY count", 32'(ready_count - readies_before), 32'd1);
    end
    total_elements += n;
    total_vectors++;
  endtask

  // Modulus width varies through a random right shift
  task automatic random_vector(output int n, output logic [15:0] m);
    logic [31:0] bits;
    logic [31:0] shift;
    int          i;
    draw_bits(3, bits);
    n = int'(bits[2:0]) + 1;
    draw_bits(4, shift);
    draw_bits(16, bits);
    m = bits[15:0] >> shift;
    if (m < 16'd2) begin
      m = m + 16'd2;
    end
    vec_base.delete();
    vec_exp.delete();
    vec_order.delete();
    for (i = 0; i < n; i++) begin
      draw_bits(16, bits);
      vec_base.push_back(bits[15:0] % m);
      draw_bits(16, bits);
      vec_exp.push_back(bits[15:0]);
      draw_bits(2, bits);
      vec_order.push_back(int'(bits[1:0]) % 3);
    end
  endtask

  task automatic add_element(input logic [15:0] base, input logic [15:0] expo,
                             input int order);
    vec_base.push_back(base);
    vec_exp.push_back(expo);
    vec_order.push_back(order);
  endtask

  //////////////////////////////////////////////////
  // Output monitor
  //////////////////////////////////////////////////

  always @(negedge CLK) begin
    if (!RST) begin
      if (data_out_enable) begin
        enable_count++;
      end
      if (ready) begin
        ready_count++;
      end
      if (ready && !data_out_enable) begin
        $display("READY pulsed without DATA_OUT_ENABLE at %0t", $time);
        errors++;
      end
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int          v;
    int          n;
    logic [15:0] m;
    CLK              = 1'b0;
    RST              = 1'b1;
    start            = 1'b0;
    size_in          = '0;
    data_a_in_enable = 1'b0;
    data_b_in_enable = 1'b0;
    modulo_in        = '0;
    data_a_in        = '0;
    data_b_in        = '0;
    lfsr             = 32'h3c00;
    errors           = 0;
    checks           = 0;
    aborted          = 1'b0;
    enable_count     = 0;
    ready_count      = 0;
    total_elements   = 0;
    total_vectors    = 0;

    repeat (16) @(posedge CLK);
    #5;
    RST = 1'b0;

    check_idle_outputs(8, 1'b1);

    // Modulus 2 with each strobe order
    vec_base.delete();
    vec_exp.delete();
    vec_order.delete();
    add_element(16'd0, 16'd3, 0);
    add_element(16'd1, 16'd0, 1);
    add_element(16'd1, 16'd1, 2);
    add_element(16'd1, 16'hffff, 0);
    run_vector(4, 16'd2);

    // Zero and one exponents, zero base, large prime modulus
    if (!aborted) begin
      vec_base.delete();
      vec_exp.delete();
      vec_order.delete();
      add_element(16'h1234, 16'd0, 0);
      add_element(16'h4321, 16'd1, 1);
      add_element(16'd0, 16'd7, 2);
      add_element(16'hfff0, 16'hffff, 0);
      add_element(16'd2, 16'h8000, 1);
      run_vector(5, 16'hfff1);
    end

    // Random vectors with each START right after the previous READY
    for (v = 0; v < RAND_VECTORS && !aborted; v++) begin
      random_vector(n, m);
      run_vector(n, m);
    end

    // No stray pulses once the last vector is done
    if (!aborted) begin
      check_idle_outputs(10, 1'b0);
      compare("DATA_OUT_ENABLE total", 32'(enable_count), 32'(total_elements));
      compare("READY total", 32'(ready_count), 32'(total_vectors));
    end

    $display("Vectors: %0d, elements: %0d, checks: %0d, errors: %0d",
             total_vectors, total_elements, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/ntm_exp_defs.svh
//////////////////////////////////////////////////
// Width definitions for the vector modular
// exponentiation unit
// Data width covers modulus, operands, result
//////////////////////////////////////////////////

`ifndef NTM_EXP_DEFS_SVH
`define NTM_EXP_DEFS_SVH

// Modulus, base, exponent and result width
// One 16 bit word per element
`define NTM_DATA_WIDTH 16

// Vector length and element counter width
// Up to 255 elements per vector
`define NTM_INDEX_WIDTH 8

`endif

//--- verilog/ntm_exp_pkg.sv
//////////////////////////////////////////////////
// Shared FSM state types for the vector modular
// exponentiation unit
//////////////////////////////////////////////////

`default_nettype none

package ntm_exp_pkg;

  // Input side controller
  typedef enum logic [1:0] {
    VEC_IDLE,
    VEC_COLLECT,
    VEC_COMPUTE
  } vec_state_t;

  // Square-and-multiply controller
  typedef enum logic [1:0] {
    EXP_IDLE,
    EXP_SQUARE,
    EXP_MULTIPLY,
    EXP_FINISH
  } exp_state_t;

  // Bit-serial multiplier
  typedef enum logic {
    MUL_IDLE,
    MUL_RUN
  } mul_state_t;

endpackage

`default_nettype wire

//--- verilog/ntm_modular_multiplier.sv
//////////////////////////////////////////////////
// Bit-serial interleaved modular multiplier
// product = a * b mod modulo, one bit of b per
// cycle, MSB first
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "ntm_exp_defs.svh"

module ntm_modular_multiplier (
  input  wire                         CLK,
  input  wire                         RST,
  input  wire                         mul_start,
  input  wire  [`NTM_DATA_WIDTH-1:0]  mul_a,
  input  wire  [`NTM_DATA_WIDTH-1:0]  mul_b,
  input  wire  [`NTM_DATA_WIDTH-1:0]  mul_modulo,
  output logic                        mul_done,
  output logic [`NTM_DATA_WIDTH-1:0]  mul_product
);

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  ntm_exp_pkg::mul_state_t              state;
  logic [$clog2(`NTM_DATA_WIDTH)-1:0]   bit_idx;

  // One extra bit for the doubled remainder
  logic [`NTM_DATA_WIDTH:0]             modulo_ext;
  logic [`NTM_DATA_WIDTH:0]             doubled;
  logic [`NTM_DATA_WIDTH:0]             doubled_red;
  logic [`NTM_DATA_WIDTH:0]             summed;
  logic [`NTM_DATA_WIDTH:0]             summed_red;

  //////////////////////////////////////////////////
  // Step datapath
  //////////////////////////////////////////////////

  assign modulo_ext = {1'b0, mul_modulo};

  // Partial remainder times two, then back below modulus
  assign doubled     = {mul_product, 1'b0};
  assign doubled_red = (doubled >= modulo_ext) ? doubled - modulo_ext : doubled;

  // Add a when the scanned bit of b is set
  // a < modulus, so one subtraction is enough
  assign summed     = mul_b[bit_idx] ? doubled_red + {1'b0, mul_a} : doubled_red;
  assign summed_red = (summed >= modulo_ext) ? summed - modulo_ext : summed;

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= ntm_exp_pkg::MUL_IDLE;
      bit_idx  <= '0;
      mul_done <= 1'b0;
    end else begin
      mul_done <= 1'b0;
      case (state)
        ntm_exp_pkg::MUL_IDLE: begin
          if (mul_start) begin
            // Scan from the top bit of b
            bit_idx <= ($clog2(`NTM_DATA_WIDTH))'(`NTM_DATA_WIDTH - 1);
            state   <= ntm_exp_pkg::MUL_RUN;
          end
        end
        ntm_exp_pkg::MUL_RUN: begin
          if (bit_idx == '0) begin
            mul_done <= 1'b1;
            state    <= ntm_exp_pkg::MUL_IDLE;
          end else begin
            bit_idx <= bit_idx - 1'b1;
          end
        end
        default: state <= ntm_exp_pkg::MUL_IDLE;
      endcase
    end
  end

  // Partial remainder, cleared on start
  always_ff @(posedge CLK) begin
    if (state == ntm_exp_pkg::MUL_IDLE && mul_start) begin
      mul_product <= '0;
    end else if (state == ntm_exp_pkg::MUL_RUN) begin
      mul_product <= summed_red[`NTM_DATA_WIDTH-1:0];
    end
  end

  // Caller waits for mul_done before the next start
  a_no_start_while_run: assert property (@(posedge CLK) disable iff (RST)
    mul_start |-> state == ntm_exp_pkg::MUL_IDLE)
    else $error("mul_start while multiplier running");

endmodule

`default_nettype wire

//--- verilog/ntm_scalar_exponentiator.sv
//////////////////////////////////////////////////
// Scalar modular exponentiator
// result = base ^ exponent mod modulo by MSB-first
// square-and-multiply on the serial multiplier
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "ntm_exp_defs.svh"

module ntm_scalar_exponentiator (
  input  wire                         CLK,
  input  wire                         RST,
  input  wire                         exp_start,
  input  wire  [`NTM_DATA_WIDTH-1:0]  exp_modulo,
  input  wire  [`NTM_DATA_WIDTH-1:0]  exp_base,
  input  wire  [`NTM_DATA_WIDTH-1:0]  exp_exponent,
  output logic                        exp_done,
  output logic [`NTM_DATA_WIDTH-1:0]  exp_result
);

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  ntm_exp_pkg::exp_state_t              state;
  logic [$clog2(`NTM_DATA_WIDTH)-1:0]   bit_idx;
  logic [`NTM_DATA_WIDTH-1:0]           acc;

  // Multiplier hookup
  logic                                 mul_start;
  logic [`NTM_DATA_WIDTH-1:0]           mul_b;
  logic                                 mul_done;
  logic [`NTM_DATA_WIDTH-1:0]           mul_product;

  //////////////////////////////////////////////////
  // Operand select
  //////////////////////////////////////////////////

  // acc stays put while the multiplier runs, so operands are held
  // Square scans acc, multiply scans the base
  assign mul_b = (state == ntm_exp_pkg::EXP_MULTIPLY) ? exp_base : acc;

  // Accumulator is stable in idle until the next start
  assign exp_result = acc;

  ntm_modular_multiplier i_multiplier (
    .CLK         (CLK),
    .RST         (RST),
    .mul_start   (mul_start),
    .mul_a       (acc),
    .mul_b       (mul_b),
    .mul_modulo  (exp_modulo),
    .mul_done    (mul_done),
    .mul_product (mul_product)
  );

  //////////////////////////////////////////////////
  // Controller
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= ntm_exp_pkg::EXP_IDLE;
      bit_idx   <= '0;
      mul_start <= 1'b0;
      exp_done  <= 1'b0;
    end else begin
      mul_start <= 1'b0;
      exp_done  <= 1'b0;
      case (state)
        ntm_exp_pkg::EXP_IDLE: begin
          if (exp_start) begin
            // All exponent bits, top first
            bit_idx   <= ($clog2(`NTM_DATA_WIDTH))'(`NTM_DATA_WIDTH - 1);
            mul_start <= 1'b1;
            state     <= ntm_exp_pkg::EXP_SQUARE;
          end
        end
        ntm_exp_pkg::EXP_SQUARE: begin
          if (mul_done) begin
            if (exp_exponent[bit_idx]) begin
              // Bit set, multiply by base next
              mul_start <= 1'b1;
              state     <= ntm_exp_pkg::EXP_MULTIPLY;
            end else if (bit_idx == '0) begin
              state <= ntm_exp_pkg::EXP_FINISH;
            end else begin
              bit_idx   <= bit_idx - 1'b1;
              mul_start <= 1'b1;
            end
          end
        end
        ntm_exp_pkg::EXP_MULTIPLY: begin
          if (mul_done) begin
            if (bit_idx == '0) begin
              state <= ntm_exp_pkg::EXP_FINISH;
            end else begin
              bit_idx   <= bit_idx - 1'b1;
              mul_start <= 1'b1;
              state     <= ntm_exp_pkg::EXP_SQUARE;
            end
          end
        end
        ntm_exp_pkg::EXP_FINISH: begin
          exp_done <= 1'b1;
          state    <= ntm_exp_pkg::EXP_IDLE;
        end
        default: state <= ntm_exp_pkg::EXP_IDLE;
      endcase
    end
  end

  // Accumulator starts at 1, zero exponent leaves it there
  always_ff @(posedge CLK) begin
    if (state == ntm_exp_pkg::EXP_IDLE && exp_start) begin
      acc <= `NTM_DATA_WIDTH'(1);
    end else if (mul_done) begin
      acc <= mul_product;
    end
  end

  // Launcher must wait for exp_done
  a_start_in_idle: assert property (@(posedge CLK) disable iff (RST)
    exp_start |-> state == ntm_exp_pkg::EXP_IDLE)
    else $error("exp_start while exponentiator busy");

endmodule

`default_nettype wire

//--- verilog/ntm_vector_exponentiator.sv
//////////////////////////////////////////////////
// Element-wise modular exponentiation unit
// DATA_OUT[i] = DATA_A_IN[i] ^ DATA_B_IN[i]
// mod MODULO_IN, one element at a time
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "ntm_exp_defs.svh"

module ntm_vector_exponentiator (
  input  wire                         CLK,
  input  wire                         RST,
  input  wire                         START,
  input  wire  [`NTM_INDEX_WIDTH-1:0] SIZE_IN,
  input  wire                         DATA_A_IN_ENABLE,
  input  wire                         DATA_B_IN_ENABLE,
  input  wire  [`NTM_DATA_WIDTH-1:0]  MODULO_IN,
  input  wire  [`NTM_DATA_WIDTH-1:0]  DATA_A_IN,
  input  wire  [`NTM_DATA_WIDTH-1:0]  DATA_B_IN,
  output logic                        READY,
  output logic                        DATA_OUT_ENABLE,
  output logic [`NTM_DATA_WIDTH-1:0]  DATA_OUT
);

  // Launch path
  logic                         exp_start;
  logic [`NTM_DATA_WIDTH-1:0]   exp_modulo;
  logic [`NTM_DATA_WIDTH-1:0]   exp_base;
  logic [`NTM_DATA_WIDTH-1:0]   exp_exponent;
  logic                         elem_last;
  // Completion path
  logic                         exp_done;
  logic [`NTM_DATA_WIDTH-1:0]   exp_result;

  ntm_vector_input i_input (
    .CLK              (CLK),
    .RST              (RST),
    .START            (START),
    .SIZE_IN          (SIZE_IN),
    .DATA_A_IN_ENABLE (DATA_A_IN_ENABLE),
    .DATA_B_IN_ENABLE (DATA_B_IN_ENABLE),
    .DATA_A_IN        (DATA_A_IN),
    .DATA_B_IN        (DATA_B_IN),
    .MODULO_IN        (MODULO_IN),
    .exp_done         (exp_done),
    .exp_start        (exp_start),
    .exp_modulo       (exp_modulo),
    .exp_base         (exp_base),
    .exp_exponent     (exp_exponent),
    .elem_last        (elem_last)
  );

  ntm_scalar_exponentiator i_exponentiator (
    .CLK          (CLK),
    .RST          (RST),
    .exp_start    (exp_start),
    .exp_modulo   (exp_modulo),
    .exp_base     (exp_base),
    .exp_exponent (exp_exponent),
    .exp_done     (exp_done),
    .exp_result   (exp_result)
  );

  ntm_vector_output i_output (
    .CLK             (CLK),
    .RST             (RST),
    .exp_done        (exp_done),
    .exp_result      (exp_result),
    .elem_last       (elem_last),
    .DATA_OUT        (DATA_OUT),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .READY           (READY)
  );

endmodule

`default_nettype wire

//--- verilog/ntm_vector_input.sv
//////////////////////////////////////////////////
// Vector input side
// Collects base/exponent pairs, counts elements
// and launches one computation per element
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "ntm_exp_defs.svh"

module ntm_vector_input (
  input  wire                         CLK,
  input  wire                         RST,
  input  wire                         START,
  input  wire  [`NTM_INDEX_WIDTH-1:0] SIZE_IN,
  input  wire                         DATA_A_IN_ENABLE,
  input  wire                         DATA_B_IN_ENABLE,
  input  wire  [`NTM_DATA_WIDTH-1:0]  DATA_A_IN,
  input  wire  [`NTM_DATA_WIDTH-1:0]  DATA_B_IN,
  input  wire  [`NTM_DATA_WIDTH-1:0]  MODULO_IN,
  input  wire                         exp_done,
  output logic                        exp_start,
  output logic [`NTM_DATA_WIDTH-1:0]  exp_modulo,
  output logic [`NTM_DATA_WIDTH-1:0]  exp_base,
  output logic [`NTM_DATA_WIDTH-1:0]  exp_exponent,
  output logic                        elem_last
);

  ntm_exp_pkg::vec_state_t          state;
  logic [`NTM_INDEX_WIDTH-1:0]      size_reg;
  logic [`NTM_INDEX_WIDTH-1:0]      count;
  logic                             a_full;
  logic                             b_full;
  logic                             a_take;
  logic                             b_take;
  logic                             launch;

  // Strobes count only while collecting, one per operand
  assign a_take = (state == ntm_exp_pkg::VEC_COLLECT) && DATA_A_IN_ENABLE && !a_full;
  assign b_take = (state == ntm_exp_pkg::VEC_COLLECT) && DATA_B_IN_ENABLE && !b_full;
  // Launch on the edge that completes the pair
  assign launch = (state == ntm_exp_pkg::VEC_COLLECT) &&
                  (a_full || a_take) && (b_full || b_take);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= ntm_exp_pkg::VEC_IDLE;
      size_reg  <= '0;
      count     <= '0;
      a_full    <= 1'b0;
      b_full    <= 1'b0;
      exp_start <= 1'b0;
      elem_last <= 1'b0;
    end else begin
      exp_start <= 1'b0;
      case (state)
        ntm_exp_pkg::VEC_IDLE: begin
          if (START) begin
            size_reg <= SIZE_IN;
            count    <= '0;
            a_full   <= 1'b0;
            b_full   <= 1'b0;
            state    <= ntm_exp_pkg::VEC_COLLECT;
          end
        end
        ntm_exp_pkg::VEC_COLLECT: begin
          if (a_take) begin
            a_full <= 1'b1;
          end
          if (b_take) begin
            b_full <= 1'b1;
          end
          if (launch) begin
            exp_start <= 1'b1;
            elem_last <= (count == size_reg - `NTM_INDEX_WIDTH'(1));
            state     <= ntm_exp_pkg::VEC_COMPUTE;
          end
        end
        ntm_exp_pkg::VEC_COMPUTE: begin
          // Flags stay set until the element is done
          if (exp_done) begin
            a_full <= 1'b0;
            b_full <= 1'b0;
            if (elem_last) begin
              state <= ntm_exp_pkg::VEC_IDLE;
            end else begin
              count <= count + 1'b1;
              state <= ntm_exp_pkg::VEC_COLLECT;
            end
          end
        end
        default: state <= ntm_exp_pkg::VEC_IDLE;
      endcase
    end
  end

  // Operand registers, held through the computation
  always_ff @(posedge CLK) begin
    if (a_take) begin
      exp_base <= DATA_A_IN;
    end
    if (b_take) begin
      exp_exponent <= DATA_B_IN;
    end
    if (launch) begin
      exp_modulo <= MODULO_IN;
    end
  end

  a_start_needs_pair: assert property (@(posedge CLK) disable iff (RST)
    exp_start |-> a_full && b_full)
    else $error("exp_start without both operands");

endmodule

`default_nettype wire

//--- verilog/ntm_vector_output.sv
//////////////////////////////////////////////////
// Vector output side
// Presents each result for one cycle and flags
// the end of the vector with READY
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "ntm_exp_defs.svh"

module ntm_vector_output (
  input  wire                         CLK,
  input  wire                         RST,
  input  wire                         exp_done,
  input  wire  [`NTM_DATA_WIDTH-1:0]  exp_result,
  input  wire                         elem_last,
  output logic [`NTM_DATA_WIDTH-1:0]  DATA_OUT,
  output logic                        DATA_OUT_ENABLE,
  output logic                        READY
);

  //////////////////////////////////////////////////
  // Result register
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      DATA_OUT        <= '0;
      DATA_OUT_ENABLE <= 1'b0;
      READY           <= 1'b0;
    end else begin
      // One enable pulse per finished element
      DATA_OUT_ENABLE <= exp_done;
      // elem_last still valid, next launch comes later
      READY           <= exp_done && elem_last;
      if (exp_done) begin
        DATA_OUT <= exp_result;
      end
    end
  end

  // End of vector always comes with its last result
  a_ready_with_enable: assert property (@(posedge CLK) disable iff (RST)
    READY |-> DATA_OUT_ENABLE)
    else $error("READY without DATA_OUT_ENABLE");

endmodule

`default_nettype wire
